// File: Makefile
# Verilator build and run of the page-table walker testbench

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f vlog.f --top-module tb_ptw -o tb_ptw

run: compile
	./obj_dir/tb_ptw | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

// File: ptw_checker.sv
// result checker for the page-table walker testbench
// queues expected walk results and compares them with the DUT pulses
`timescale 1ns/1ps
`default_nettype none

module ptw_checker (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 itlb_update_valid_i,
    input  logic                 dtlb_update_valid_i,
    input  logic                 ptw_error_i,
    input  logic                 ptw_active_i,
    input  ptw_pkg::tlb_update_t tlb_update_i,
    input  logic [15:0]          update_asid_i,
    input  logic                 exp_push_i,
    input  logic [1:0]           exp_kind_i,
    input  ptw_pkg::tlb_update_t exp_upd_i,
    input  logic [15:0]          exp_asid_i,
    output int                   tests_o,
    output int                   errors_o
);
    import ptw_pkg::*;

    localparam logic [1:0] K_ITLB  = 2'd0;
    localparam logic [1:0] K_DTLB  = 2'd1;
    localparam logic [1:0] K_FAULT = 2'd2;

    logic [1:0]  exp_kinds [$];
    tlb_update_t exp_upds [$];
    logic [15:0] exp_asids [$];
    int          tests  = 0;
    int          errors = 0;

    assign tests_o  = tests;
    assign errors_o = errors;

    function automatic logic field_ok(input string name, input logic [63:0] exp_v,
                                      input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic string kind_name(input logic [1:0] kind);
        if (kind == K_ITLB) begin
            return "itlb update";
        end else if (kind == K_DTLB) begin
            return "dtlb update";
        end
        return "page fault";
    endfunction

    // ----------------------------------------
    // compare each result pulse in walk order
    // ----------------------------------------
    always @(posedge clk_i) begin
        logic [1:0]  act_kind;
        logic [1:0]  want_kind;
        tlb_update_t want;
        logic [15:0] want_asid;
        logic        ok;
        if (rst_ni && exp_push_i) begin
            exp_kinds.push_back(exp_kind_i);
            exp_upds.push_back(exp_upd_i);
            exp_asids.push_back(exp_asid_i);
        end
        if (rst_ni && (itlb_update_valid_i || dtlb_update_valid_i || ptw_error_i)) begin
            act_kind = itlb_update_valid_i ? K_ITLB : (dtlb_update_valid_i ? K_DTLB : K_FAULT);
            if (exp_kinds.size() == 0) begin
                errors++;
                $display("error at %0t: result pulse with no walk outstanding", $time);
            end else begin
                want_kind = exp_kinds.pop_front();
                want      = exp_upds.pop_front();
                want_asid = exp_asids.pop_front();
                ok = field_ok("result pulse kind", 64'(want_kind), 64'(act_kind));
                // the walker stays active through the cycle of its pulse
                ok &= field_ok("ptw_active_o", 64'd1, 64'(ptw_active_i));
                if (ok && (want_kind != K_FAULT)) begin
                    ok &= field_ok("tlb_update_o.vpn", 64'(want.vpn), 64'(tlb_update_i.vpn));
                    ok &= field_ok("tlb_update_o.is_1g", 64'(want.is_1g),
                                   64'(tlb_update_i.is_1g));
                    ok &= field_ok("tlb_update_o.is_2m", 64'(want.is_2m),
                                   64'(tlb_update_i.is_2m));
                    ok &= field_ok("tlb_update_o.content", 64'(want.content),
                                   64'(tlb_update_i.content));
                    ok &= field_ok("update_asid_o", 64'(want_asid), 64'(update_asid_i));
                end
                tests++;
                if (!ok) begin
                    errors++;
                end
                $display("test %0d: %s %s", tests, kind_name(want_kind), ok ? "ok" : "failed");
            end
        end
    end

endmodule

`default_nettype wire

// File: ptw_pkg.sv
// shared types for the Sv39 page-table walker
// address and page number widths, PTE layout, walk enums
// and the structs passed between walker stages
`default_nettype none

package ptw_pkg;

    // one level of the table is indexed by 9 bits of the vpn
    localparam int PTE_IDX_W = 9;

    typedef logic [38:0] vaddr_t;
    typedef logic [55:0] paddr_t;
    typedef logic [43:0] ppn_t;
    typedef logic [26:0] vpn_t;

    // Sv39 page-table entry, flags in the low byte
    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // LVL1 holds 1G pages, LVL3 holds 4K pages
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    typedef enum logic [1:0] {
        PTE_POINTER,
        PTE_LEAF,
        PTE_FAULT
    } pte_class_e;

    typedef enum logic [2:0] {
        IDLE,
        SEND_REQ,
        WAIT_RSP,
        CHECK,
        DRAIN
    } walk_state_e;

    typedef struct packed {
        vpn_t vpn;
        logic is_2m;
        logic is_1g;
        pte_t content;
    } tlb_update_t;

    // end-of-walk summary from the walker to the update stage
    typedef struct packed {
        logic     done_ok;
        logic     fault;
        logic     is_instr;
        ptw_lvl_e level;
        pte_t     pte;
        logic     global_bit;
        vpn_t     vpn;
    } walk_result_t;

endpackage

`default_nettype wire

// File: ptw_pte_check.sv
// PTE classification for the walker
// decides pointer, leaf or fault for a fetched entry
`timescale 1ns/1ps
`default_nettype none

module ptw_pte_check (
    input  ptw_pkg::pte_t       pte_i,
    input  ptw_pkg::ptw_lvl_e   level_i,
    input  logic                is_instr_i,
    input  logic                is_store_i,
    input  logic                mxr_i,
    output ptw_pkg::pte_class_e class_o
);
    import ptw_pkg::*;

    logic is_leaf;
    logic bad_entry;
    logic misaligned;
    logic perm_fault;

    // r = 0 with w = 1 is reserved encoding
    assign bad_entry = !pte_i.v || (!pte_i.r && pte_i.w);
    assign is_leaf   = pte_i.r || pte_i.x;

    // superpages need the low ppn bits clear
    assign misaligned = ((level_i == LVL1) && (pte_i.ppn[17:0] != '0)) ||
                        ((level_i == LVL2) && (pte_i.ppn[8:0] != '0));

    // ----------------------------------------
    // leaf permission checks
    // ----------------------------------------
    always_comb begin
        perm_fault = 1'b0;
        if (!pte_i.a) begin
            perm_fault = 1'b1;
        end
        if (is_instr_i) begin
            if (!pte_i.x) begin
                perm_fault = 1'b1;
            end
        end else begin
            // mxr lets loads read execute-only pages
            if (!(pte_i.r || (pte_i.x && mxr_i))) begin
                perm_fault = 1'b1;
            end
            if (is_store_i && (!pte_i.w || !pte_i.d)) begin
                perm_fault = 1'b1;
            end
        end
    end

    always_comb begin
        if (bad_entry) begin
            class_o = PTE_FAULT;
        end else if (!is_leaf) begin
            // no level left below LVL3
            class_o = (level_i == LVL3) ? PTE_FAULT : PTE_POINTER;
        end else if (perm_fault || misaligned) begin
            class_o = PTE_FAULT;
        end else begin
            class_o = PTE_LEAF;
        end
    end

    always_comb begin
        if (!$isunknown({pte_i, level_i, is_instr_i, is_store_i, mxr_i})) begin
            a_class_known: assert (!$isunknown(class_o));
        end
    end

endmodule

`default_nettype wire

// File: ptw_tlb_update.sv
// TLB update forming
// registers the update payload and the itlb, dtlb or fault pulse
`timescale 1ns/1ps
`default_nettype none

module ptw_tlb_update #(
    parameter int ASID_WIDTH = 16
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    result_valid_i,
    input  ptw_pkg::walk_result_t   result_i,
    input  logic [ASID_WIDTH-1:0]   asid_i,
    output logic                    itlb_update_valid_o,
    output logic                    dtlb_update_valid_o,
    output ptw_pkg::tlb_update_t    tlb_update_o,
    output logic [ASID_WIDTH-1:0]   update_asid_o,
    output logic                    ptw_error_o
);
    import ptw_pkg::*;

    pte_t leaf;

    // g seen on any level of the walk marks the mapping global
    always_comb begin
        leaf   = result_i.pte;
        leaf.g = result_i.global_bit;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            itlb_update_valid_o <= 1'b0;
            dtlb_update_valid_o <= 1'b0;
            ptw_error_o         <= 1'b0;
        end else begin
            itlb_update_valid_o <= result_valid_i && result_i.done_ok && result_i.is_instr;
            dtlb_update_valid_o <= result_valid_i && result_i.done_ok && !result_i.is_instr;
            ptw_error_o         <= result_valid_i && result_i.fault;
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (result_valid_i) begin
            tlb_update_o.vpn     <= result_i.vpn;
            tlb_update_o.is_1g   <= (result_i.level == LVL1);
            tlb_update_o.is_2m   <= (result_i.level == LVL2);
            tlb_update_o.content <= leaf;
            update_asid_o        <= asid_i;
        end
    end

    a_one_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({itlb_update_valid_o, dtlb_update_valid_o, ptw_error_o}));

endmodule

`default_nettype wire

// File: ptw_top.sv
// Sv39 page-table walker top level
// walker, PTE check and update stage
`timescale 1ns/1ps
`default_nettype none

module ptw_top #(
    parameter int ASID_WIDTH = 16
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    itlb_miss_i,
    input  ptw_pkg::vaddr_t         itlb_vaddr_i,
    input  logic                    dtlb_miss_i,
    input  ptw_pkg::vaddr_t         dtlb_vaddr_i,
    input  logic                    lsu_is_store_i,
    input  logic                    mxr_i,
    input  ptw_pkg::ppn_t           satp_ppn_i,
    input  logic [ASID_WIDTH-1:0]   asid_i,
    input  logic                    mem_req_ready_i,
    input  logic                    mem_rsp_valid_i,
    input  logic [63:0]             mem_rsp_data_i,
    output logic                    mem_req_valid_o,
    output ptw_pkg::paddr_t         mem_req_addr_o,
    output logic                    ptw_active_o,
    output logic                    itlb_update_valid_o,
    output logic                    dtlb_update_valid_o,
    output ptw_pkg::tlb_update_t    tlb_update_o,
    output logic [ASID_WIDTH-1:0]   update_asid_o,
    output logic                    ptw_error_o
);
    import ptw_pkg::*;

    pte_t                  pte;
    ptw_lvl_e              level;
    logic                  is_instr;
    logic                  is_store;
    pte_class_e            pte_class;
    logic                  result_valid;
    walk_result_t          result;
    logic [ASID_WIDTH-1:0] walk_asid;

    ptw_walk_fsm #(
        .ASID_WIDTH (ASID_WIDTH)
    ) u_walk (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .itlb_miss_i     (itlb_miss_i),
        .itlb_vaddr_i    (itlb_vaddr_i),
        .dtlb_miss_i     (dtlb_miss_i),
        .dtlb_vaddr_i    (dtlb_vaddr_i),
        .lsu_is_store_i  (lsu_is_store_i),
        .satp_ppn_i      (satp_ppn_i),
        .asid_i          (asid_i),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .class_i         (pte_class),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .ptw_active_o    (ptw_active_o),
        .pte_o           (pte),
        .level_o         (level),
        .is_instr_o      (is_instr),
        .is_store_o      (is_store),
        .result_valid_o  (result_valid),
        .result_o        (result),
        .asid_o          (walk_asid)
    );

    ptw_pte_check u_pte_check (
        .pte_i      (pte),
        .level_i    (level),
        .is_instr_i (is_instr),
        .is_store_i (is_store),
        .mxr_i      (mxr_i),
        .class_o    (pte_class)
    );

    ptw_tlb_update #(
        .ASID_WIDTH (ASID_WIDTH)
    ) u_update (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .result_valid_i      (result_valid),
        .result_i            (result),
        .asid_i              (walk_asid),
        .itlb_update_valid_o (itlb_update_valid_o),
        .dtlb_update_valid_o (dtlb_update_valid_o),
        .tlb_update_o        (tlb_update_o),
        .update_asid_o       (update_asid_o),
        .ptw_error_o         (ptw_error_o)
    );

endmodule

`default_nettype wire

// File: ptw_walk_fsm.sv
// walk sequencing for Sv39 translation
// miss arbitration, pointer forming, memory request
// and the walk result handed to the update stage
`timescale 1ns/1ps
`default_nettype none

module ptw_walk_fsm #(
    parameter int ASID_WIDTH = 16
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    itlb_miss_i,
    input  ptw_pkg::vaddr_t         itlb_vaddr_i,
    input  logic                    dtlb_miss_i,
    input  ptw_pkg::vaddr_t         dtlb_vaddr_i,
    input  logic                    lsu_is_store_i,
    input  ptw_pkg::ppn_t           satp_ppn_i,
    input  logic [ASID_WIDTH-1:0]   asid_i,
    input  logic                    mem_req_ready_i,
    input  logic                    mem_rsp_valid_i,
    input  logic [63:0]             mem_rsp_data_i,
    input  ptw_pkg::pte_class_e     class_i,
    output logic                    mem_req_valid_o,
    output ptw_pkg::paddr_t         mem_req_addr_o,
    output logic                    ptw_active_o,
    output ptw_pkg::pte_t           pte_o,
    output ptw_pkg::ptw_lvl_e       level_o,
    output logic                    is_instr_o,
    output logic                    is_store_o,
    output logic                    result_valid_o,
    output ptw_pkg::walk_result_t   result_o,
    output logic [ASID_WIDTH-1:0]   asid_o
);
    import ptw_pkg::*;

    walk_state_e           state_q, state_d;
    ptw_lvl_e              level_q, level_d;
    paddr_t                pptr_q, pptr_d;
    vaddr_t                vaddr_q;
    vaddr_t                sel_vaddr;
    pte_t                  pte_q;
    logic [ASID_WIDTH-1:0] asid_q;
    logic                  is_instr_q;
    logic                  is_store_q;
    logic                  global_q;
    logic                  result_q;
    logic                  accept;
    logic [PTE_IDX_W-1:0]  next_idx;
    ptw_lvl_e              next_lvl;

    // itlb wins when both miss together
    assign sel_vaddr = itlb_miss_i ? itlb_vaddr_i : dtlb_vaddr_i;
    // hold off while the previous result pulse is still out
    assign accept = (state_q == IDLE) && !result_q && !flush_i &&
                    (itlb_miss_i || dtlb_miss_i);

    always_comb begin
        if (level_q == LVL1) begin
            next_lvl = LVL2;
            next_idx = vaddr_q[29:21];
        end else begin
            next_lvl = LVL3;
            next_idx = vaddr_q[20:12];
        end
    end

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        level_d = level_q;
        pptr_d  = pptr_q;
        unique case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = SEND_REQ;
                    level_d = LVL1;
                    pptr_d  = {satp_ppn_i, sel_vaddr[38:30], 3'b000};
                end
            end
            SEND_REQ: begin
                if (flush_i) begin
                    // an accepted request still owes a response
                    state_d = mem_req_ready_i ? DRAIN : IDLE;
                end else if (mem_req_ready_i) begin
                    state_d = WAIT_RSP;
                end
            end
            WAIT_RSP: begin
                if (flush_i) begin
                    state_d = mem_rsp_valid_i ? IDLE : DRAIN;
                end else if (mem_rsp_valid_i) begin
                    state_d = CHECK;
                end
            end
            CHECK: begin
                if (flush_i || (class_i != PTE_POINTER)) begin
                    state_d = IDLE;
                end else begin
                    state_d = SEND_REQ;
                    level_d = next_lvl;
                    pptr_d  = {pte_q.ppn, next_idx, 3'b000};
                end
            end
            DRAIN: begin
                if (mem_rsp_valid_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            level_q    <= LVL1;
            is_instr_q <= 1'b0;
            is_store_q <= 1'b0;
            global_q   <= 1'b0;
            result_q   <= 1'b0;
        end else begin
            state_q  <= state_d;
            level_q  <= level_d;
            result_q <= result_valid_o;
            if (accept) begin
                is_instr_q <= itlb_miss_i;
                is_store_q <= !itlb_miss_i && lsu_is_store_i;
                global_q   <= 1'b0;
            end else if ((state_q == CHECK) && (class_i == PTE_POINTER)) begin
                global_q <= global_q | pte_q.g;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        pptr_q <= pptr_d;
        if (accept) begin
            vaddr_q <= sel_vaddr;
            asid_q  <= asid_i;
        end
        if ((state_q == WAIT_RSP) && mem_rsp_valid_i) begin
            pte_q <= pte_t'(mem_rsp_data_i);
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign mem_req_valid_o = (state_q == SEND_REQ);
    assign mem_req_addr_o  = pptr_q;
    assign ptw_active_o    = (state_q != IDLE) || result_q;

    assign pte_o      = pte_q;
    assign level_o    = level_q;
    assign is_instr_o = is_instr_q;
    assign is_store_o = is_store_q;
    assign asid_o     = asid_q;

    assign result_valid_o = (state_q == CHECK) && !flush_i && (class_i != PTE_POINTER);

    assign result_o.done_ok    = (class_i == PTE_LEAF);
    assign result_o.fault      = (class_i == PTE_FAULT);
    assign result_o.is_instr   = is_instr_q;
    assign result_o.level      = level_q;
    assign result_o.pte        = pte_q;
    assign result_o.global_bit = global_q | pte_q.g;
    assign result_o.vpn        = vaddr_q[38:12];

    a_req_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i && !flush_i
        |=> mem_req_valid_o && $stable(mem_req_addr_o));

endmodule

`default_nettype wire

// File: tb_ptw.sv
// testbench for the Sv39 page-table walker
// clock, reset, page-table memory model, reference walk,
// directed walks and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_ptw;
    import ptw_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int ASID_W     = 16;
    // fifteen checked walks plus the flushed one
    localparam int NUM_TESTS  = 16;

    localparam logic [1:0] K_ITLB  = 2'd0;
    localparam logic [1:0] K_DTLB  = 2'd1;
    localparam logic [1:0] K_FAULT = 2'd2;

    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_G = 8'h20;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    localparam ppn_t ROOT_PPN = 44'h100;
    localparam ppn_t T1_PPN   = 44'h101;
    localparam ppn_t T2_PPN   = 44'h102;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              itlb_miss;
    vaddr_t            itlb_vaddr;
    logic              dtlb_miss;
    vaddr_t            dtlb_vaddr;
    logic              lsu_is_store;
    logic              mxr;
    ppn_t              satp_ppn;
    logic [ASID_W-1:0] asid;
    logic              mem_req_ready = 1'b0;
    logic              mem_rsp_valid = 1'b0;
    logic [63:0]       mem_rsp_data  = '0;

    logic              mem_req_valid;
    paddr_t            mem_req_addr;
    logic              ptw_active;
    logic              itlb_update_valid;
    logic              dtlb_update_valid;
    tlb_update_t       tlb_update;
    logic [ASID_W-1:0] update_asid;
    logic              ptw_error;

    logic              exp_push;
    logic [1:0]        exp_kind;
    tlb_update_t       exp_upd;
    logic [ASID_W-1:0] exp_asid;
    int                chk_tests;
    int                chk_errors;
    int                flush_errors = 0;

    // page tables keyed by the byte address of each PTE
    logic [63:0] mem [paddr_t];
    int          ready_wait  = 0;
    int          rsp_wait    = 0;
    logic        rsp_pending = 1'b0;
    paddr_t      rsp_addr    = '0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    ptw_top #(
        .ASID_WIDTH (ASID_W)
    ) u_dut (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .flush_i             (flush),
        .itlb_miss_i         (itlb_miss),
        .itlb_vaddr_i        (itlb_vaddr),
        .dtlb_miss_i         (dtlb_miss),
        .dtlb_vaddr_i        (dtlb_vaddr),
        .lsu_is_store_i      (lsu_is_store),
        .mxr_i               (mxr),
        .satp_ppn_i          (satp_ppn),
        .asid_i              (asid),
        .mem_req_ready_i     (mem_req_ready),
        .mem_rsp_valid_i     (mem_rsp_valid),
        .mem_rsp_data_i      (mem_rsp_data),
        .mem_req_valid_o     (mem_req_valid),
        .mem_req_addr_o      (mem_req_addr),
        .ptw_active_o        (ptw_active),
        .itlb_update_valid_o (itlb_update_valid),
        .dtlb_update_valid_o (dtlb_update_valid),
        .tlb_update_o        (tlb_update),
        .update_asid_o       (update_asid),
        .ptw_error_o         (ptw_error)
    );

    ptw_checker u_chk (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .itlb_update_valid_i (itlb_update_valid),
        .dtlb_update_valid_i (dtlb_update_valid),
        .ptw_error_i         (ptw_error),
        .ptw_active_i        (ptw_active),
        .tlb_update_i        (tlb_update),
        .update_asid_i       (update_asid),
        .exp_push_i          (exp_push),
        .exp_kind_i          (exp_kind),
        .exp_upd_i           (exp_upd),
        .exp_asid_i          (exp_asid),
        .tests_o             (chk_tests),
        .errors_o            (chk_errors)
    );

    function automatic logic [63:0] read_pte(input paddr_t addr);
        return mem.exists(addr) ? mem[addr] : 64'd0;
    endfunction

    function automatic void set_pte(input ppn_t tbl, input int idx, input ppn_t ppn,
                                    input logic [7:0] flags);
        mem[{tbl, 9'(idx), 3'b000}] = {10'd0, ppn, 2'b00, flags};
    endfunction

    function automatic vaddr_t make_va(input int v2, input int v1, input int v0);
        return {9'(v2), 9'(v1), 9'(v0), 12'($urandom)};
    endfunction

    // ----------------------------------------
    // memory model
    // ----------------------------------------
    // ready comes 0 to 3 cycles after the last handshake, response 1 to 4 after
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            rsp_pending = 1'b0;
            ready_wait  = 0;
        end else begin
            mem_rsp_valid <= 1'b0;
            if (rsp_pending) begin
                if (rsp_wait == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_data  <= read_pte(rsp_addr);
                    rsp_pending = 1'b0;
                end else begin
                    rsp_wait--;
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                rsp_pending = 1'b1;
                rsp_wait    = $urandom_range(3, 0);
                rsp_addr    = mem_req_addr;
                ready_wait  = $urandom_range(3, 0);
                mem_req_ready <= 1'b0;
            end else if (ready_wait > 0) begin
                ready_wait--;
            end else begin
                mem_req_ready <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // reference walk
    // ----------------------------------------
    function automatic logic [1:0] ref_walk(input vaddr_t va, input logic is_instr,
                                            input logic store, input logic mxr_v,
                                            output tlb_update_t upd);
        ppn_t   table_ppn;
        pte_t   pte;
        logic   g_seen;
        logic   leaf_bad;
        logic   data_store;
        table_ppn  = satp_ppn;
        g_seen     = 1'b0;
        data_store = store && !is_instr;
        upd        = '0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            pte = pte_t'(read_pte({table_ppn, va[30 - 9 * lvl +: 9], 3'b000}));
            if (!pte.v || (pte.w && !pte.r)) begin
                return K_FAULT;
            end
            if (pte.r || pte.x) begin
                leaf_bad = !pte.a;
                leaf_bad |= is_instr && !pte.x;
                leaf_bad |= !is_instr && !pte.r && !(mxr_v && pte.x);
                leaf_bad |= data_store && !(pte.w && pte.d);
                leaf_bad |= (lvl == 0) && (pte.ppn[17:0] != 18'd0);
                leaf_bad |= (lvl == 1) && (pte.ppn[8:0] != 9'd0);
                if (leaf_bad) begin
                    return K_FAULT;
                end
                upd.vpn       = va[38:12];
                upd.is_1g     = (lvl == 0);
                upd.is_2m     = (lvl == 1);
                upd.content   = pte;
                upd.content.g = g_seen | pte.g;
                return is_instr ? K_ITLB : K_DTLB;
            end
            g_seen    = g_seen | pte.g;
            table_ppn = pte.ppn;
        end
        // pointer found at the 4K level
        return K_FAULT;
    endfunction

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic push_expect(input logic [1:0] kind, input tlb_update_t upd,
                               input logic [ASID_W-1:0] walk_asid);
        exp_push <= 1'b1;
        exp_kind <= kind;
        exp_upd  <= upd;
        exp_asid <= walk_asid;
        @(posedge clk);
        exp_push <= 1'b0;
    endtask

    task automatic wait_pulse();
        @(posedge clk);
        while (!(itlb_update_valid || dtlb_update_valid || ptw_error)) begin
            @(posedge clk);
        end
    endtask

    task automatic run_walk(input logic is_instr, input vaddr_t va, input logic store,
                            input logic mxr_v);
        tlb_update_t       upd;
        logic [1:0]        kind;
        logic [ASID_W-1:0] walk_asid;
        walk_asid = ASID_W'($urandom);
        kind      = ref_walk(va, is_instr, store, mxr_v, upd);
        push_expect(kind, upd, walk_asid);
        asid         <= walk_asid;
        mxr          <= mxr_v;
        lsu_is_store <= store;
        if (is_instr) begin
            itlb_miss  <= 1'b1;
            itlb_vaddr <= va;
        end else begin
            dtlb_miss  <= 1'b1;
            dtlb_vaddr <= va;
        end
        wait_pulse();
        itlb_miss    <= 1'b0;
        dtlb_miss    <= 1'b0;
        lsu_is_store <= 1'b0;
    endtask

    // both TLBs miss in the same cycle and each holds until its own pulse
    task automatic run_dual(input vaddr_t iva, input vaddr_t dva);
        tlb_update_t       iupd;
        tlb_update_t       dupd;
        logic [1:0]        ikind;
        logic [1:0]        dkind;
        logic [ASID_W-1:0] walk_asid;
        walk_asid = ASID_W'($urandom);
        ikind     = ref_walk(iva, 1'b1, 1'b0, 1'b0, iupd);
        dkind     = ref_walk(dva, 1'b0, 1'b0, 1'b0, dupd);
        push_expect(ikind, iupd, walk_asid);
        push_expect(dkind, dupd, walk_asid);
        asid       <= walk_asid;
        mxr        <= 1'b0;
        itlb_miss  <= 1'b1;
        itlb_vaddr <= iva;
        dtlb_miss  <= 1'b1;
        dtlb_vaddr <= dva;
        wait_pulse();
        itlb_miss <= 1'b0;
        wait_pulse();
        dtlb_miss <= 1'b0;
    endtask

    task automatic flush_during_walk(input vaddr_t va);
        logic pulse_seen;
        pulse_seen = 1'b0;
        mxr        <= 1'b0;
        dtlb_miss  <= 1'b1;
        dtlb_vaddr <= va;
        @(posedge clk);
        while (!(mem_req_valid && mem_req_ready)) begin
            @(posedge clk);
        end
        // the first PTE read is accepted and its response is still owed
        flush     <= 1'b1;
        dtlb_miss <= 1'b0;
        @(posedge clk);
        flush <= 1'b0;
        while (ptw_active) begin
            pulse_seen |= itlb_update_valid || dtlb_update_valid || ptw_error;
            @(posedge clk);
        end
        if (pulse_seen) begin
            flush_errors++;
            $display("test flush: result pulse seen after the flush at %0t", $time);
        end else begin
            $display("test flush: walk abandoned, walker idle at %0t", $time);
        end
    endtask

    initial begin
        void'($urandom(32'hbeb1ad59));
        clk          = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        itlb_miss    = 1'b0;
        itlb_vaddr   = '0;
        dtlb_miss    = 1'b0;
        dtlb_vaddr   = '0;
        lsu_is_store = 1'b0;
        mxr          = 1'b0;
        satp_ppn     = ROOT_PPN;
        asid         = '0;
        exp_push     = 1'b0;
        exp_kind     = K_FAULT;
        exp_upd      = '0;
        exp_asid     = '0;

        // root index 3 stays empty and reads as an invalid entry
        set_pte(ROOT_PPN, 1, T1_PPN, F_V | F_G);
        set_pte(ROOT_PPN, 2, 44'h40000, F_V | F_R | F_W | F_A | F_D);
        set_pte(ROOT_PPN, 4, 44'h777, F_V | F_W | F_A);
        set_pte(T1_PPN, 2, T2_PPN, F_V);
        set_pte(T1_PPN, 5, 44'h600, F_V | F_R | F_A);
        set_pte(T1_PPN, 6, 44'h601, F_V | F_R | F_A);
        set_pte(T2_PPN, 3, 44'h5555, F_V | F_R | F_X | F_A);
        set_pte(T2_PPN, 4, 44'h1234, F_V | F_R);
        set_pte(T2_PPN, 5, 44'h1235, F_V | F_R | F_A);
        set_pte(T2_PPN, 6, 44'h1236, F_V | F_R | F_W | F_A);
        set_pte(T2_PPN, 7, 44'h103, F_V);
        set_pte(T2_PPN, 8, 44'h1238, F_V | F_X | F_A);
        set_pte(T2_PPN, 9, 44'h1239, F_V | F_R | F_W | F_A | F_D);

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // 4K instruction page that inherits g from the root pointer
        run_walk(1'b1, make_va(1, 2, 3), 1'b0, 1'b0);
        // 1G and 2M data pages
        run_walk(1'b0, make_va(2, 0, 0), 1'b0, 1'b0);
        run_walk(1'b0, make_va(1, 5, 0), 1'b0, 1'b0);
        // invalid, w without r, a clear, no x, clean store, misaligned 2M, pointer at 4K
        run_walk(1'b0, make_va(3, 0, 0), 1'b0, 1'b0);
        run_walk(1'b0, make_va(4, 0, 0), 1'b0, 1'b0);
        run_walk(1'b0, make_va(1, 2, 4), 1'b0, 1'b0);
        run_walk(1'b1, make_va(1, 2, 5), 1'b0, 1'b0);
        run_walk(1'b0, make_va(1, 2, 6), 1'b1, 1'b0);
        run_walk(1'b0, make_va(1, 6, 0), 1'b0, 1'b0);
        run_walk(1'b0, make_va(1, 2, 7), 1'b0, 1'b0);
        // execute-only page loaded without and with mxr
        run_walk(1'b0, make_va(1, 2, 8), 1'b0, 1'b0);
        run_walk(1'b0, make_va(1, 2, 8), 1'b0, 1'b1);
        run_dual(make_va(1, 2, 3), make_va(1, 5, 0));
        flush_during_walk(make_va(1, 2, 3));
        run_walk(1'b0, make_va(1, 2, 9), 1'b1, 1'b0);

        repeat (2) @(posedge clk);
        $display("tests %0d, errors %0d", chk_tests + 1, chk_errors + flush_errors);
        if ((chk_errors == 0) && (flush_errors == 0) && (chk_tests == NUM_TESTS - 1)) begin
            $display("Simulation finished: PASS");
        end else begin
            if (chk_tests != NUM_TESTS - 1) begin
                $display("only %0d of %0d walk results were checked", chk_tests, NUM_TESTS - 1);
            end
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog with a generous bound per test
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout: walks did not complete within %0d cycles", NUM_TESTS * 200);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
ptw_pkg.sv
ptw_pte_check.sv
ptw_walk_fsm.sv
ptw_tlb_update.sv
ptw_top.sv
ptw_checker.sv
tb_ptw.sv
